// ==== tests/programInput.txt ====
// Per test: program length, instruction words, writeback count, then
// (destination register, data) pairs in retire order; a length of 00 ends the file
// Arithmetic and logic
0F
20010005 2002FFFD 20030F0F 340C8001
00222020 00222822 0041302A 00623824
00614025 00624826 0022502A 304BFF00
284DFFFE 282E8000 00857820
0F
01 00000005  02 FFFFFFFD  03 00000F0F  0C 00008001
04 00000002  05 00000008  06 00000001  07 00000F0D
08 00000F0F  09 FFFFF0F2  0A 00000000  0B 0000FF00
0D 00000001  0E 00000000  0F 0000000A
// Register zero
07
20000007 20101234 3400FFFF 00000000
00108820 00009025 00109822
04
10 00001234  11 00001234  12 00000000  13 FFFFEDCC
// Store and load at two addresses
0C
200155AA 2002FFFF 20030020 AC010008
20040077 AC620004 8C050008 8C060024
AC040008 8C070008 8C680004 00A64820
09
01 000055AA  02 FFFFFFFF  03 00000020  04 00000077
05 000055AA  06 FFFFFFFF  07 00000077  08 FFFFFFFF
09 000055A9
// Taken beq with three slots, then a beq that falls through
10
20010003 20020003 20030009 00000000
10220005 20040011 20050022 20060033
20070044 20080055 10230004 20090066
200A0077 200B0088 200C0099 200D00AA
0B
01 00000003  02 00000003  03 00000009  04 00000011
05 00000022  06 00000033  09 00000066  0A 00000077
0B 00000088  0C 00000099  0D 000000AA
// End of tests
00

// ==== filelist.f ====
src/mipsPkg.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/mipsPipeline.sv
tests/clockGen.sv
tests/mipsPipeline_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module mipsPipeline_tb -f filelist.f -o simv || exit 1
simOut=$(./obj_dir/simv)
printf '%s\n' "$simOut"
printf '%s\n' "$simOut" | grep -qF '*** TEST PASSED ***' && echo "run.sh: PASS" \
    || { echo "run.sh: FAIL"; exit 1; }

// ==== tests/mipsPipeline_tb.sv ====
`timescale 1ns/1ps

module mipsPipeline_tb
    import mipsPkg::*;
();

    localparam int    IMEM_WORDS   = 64;
    localparam int    DMEM_WORDS   = 64;
    localparam int    STIM_WORDS   = 256;
    localparam int    RESET_CYCLES = 16;
    localparam int    TAIL_CYCLES  = 4;
    // addi $31, $0, 0x7bad
    localparam word_t JUNK_INSTR   = 32'h201F_7BAD;

    logic      clk;
    logic      arstN;
    logic      run;
    imemLoad_t load;
    logic      loadValid;
    logic      loadReady;
    wb_t       wb;

    word_t  stim [0:STIM_WORDS-1];
    integer seed;
    int     errorCount;
    int     checkCount;
    int     testCount;
    int     cycleLimit;
    int     cycleCount = 0;

    clockGen #(
        .PERIOD_NS    (4),
        .RESET_CYCLES (RESET_CYCLES)
    ) clockGen_i (
        .o_clk   (clk),
        .o_arstN (arstN)
    );

    mipsPipeline #(
        .IMEM_WORDS (IMEM_WORDS),
        .DMEM_WORDS (DMEM_WORDS)
    ) mipsPipeline_i (
        .i_clk       (clk),
        .i_arstN     (arstN),
        .i_run       (run),
        .i_load      (load),
        .i_loadValid (loadValid),
        .o_loadReady (loadReady),
        .o_wb        (wb)
    );

    //////////////////////////////
    // Checks
    //////////////////////////////
    task automatic checkWb(input wb_t actual, input wb_t expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[FAIL] o_wb: got valid=%h reg=%h data=%h, expected valid=%h reg=%h data=%h",
                     actual.valid, actual.destReg, actual.data,
                     expected.valid, expected.destReg, expected.data);
        end
    endtask

    task automatic checkReady(input logic actual, input logic expected, input string phase);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[FAIL] o_loadReady while %s: got %h, expected %h", phase, actual, expected);
        end
    endtask

    //////////////////////////////
    // Stimulus file walking
    //////////////////////////////
    function automatic logic hasRecord(input int ptr);
        return (ptr < STIM_WORDS) && !$isunknown(stim[ptr]) && (stim[ptr] != '0);
    endfunction

    // Program cycles and 20 per test plus a full memory load with gaps
    function automatic int cycleBudget();
        int ptr;
        int len;
        int total;
        ptr   = 0;
        total = RESET_CYCLES + 2;
        while (hasRecord(ptr)) begin
            len   = int'(stim[ptr]);
            total = total + len + 20 + 2 * IMEM_WORDS + 2;
            ptr   = ptr + len + 2 + 2 * int'(stim[ptr + len + 1]);
        end
        return total;
    endfunction

    // Harmless add into r0 with operand fields taken from the address
    function automatic word_t fillWord(input word_t slot);
        return {6'h00, slot[9:0], 5'd0, slot[14:10], 6'h20};
    endfunction

    //////////////////////////////
    // Load and run
    //////////////////////////////
    task automatic loadProgram(input int base, input int len);
        int gap;
        checkReady(loadReady, 1'b1, "stopped");
        for (int addr = 0; addr < IMEM_WORDS; addr++) begin
            gap = $random(seed) & 1;
            if (gap != 0) begin
                loadValid = 1'b0;
                @(negedge clk);
            end
            load.addr = word_t'(addr);
            load.data = (addr < len) ? stim[base + addr] : fillWord(word_t'(addr));
            loadValid = 1'b1;
            @(negedge clk);
            if (wb.valid) begin
                errorCount++;
                $display("Writeback seen while the core is stopped and loading");
            end
        end
        loadValid = 1'b0;
    endtask

    // Junk words are offered ahead of the PC the whole time the core runs
    task automatic runProgram(input int expBase, input int expCount);
        int  seen;
        int  quiet;
        int  runCycle;
        wb_t expected;
        seen     = 0;
        quiet    = 0;
        runCycle = 0;
        run      = 1'b1;
        while (seen < expCount || quiet < TAIL_CYCLES) begin
            load.addr = word_t'((runCycle + 2) % IMEM_WORDS);
            load.data = JUNK_INSTR;
            loadValid = 1'b1;
            @(negedge clk);
            runCycle++;
            checkReady(loadReady, 1'b0, "running");
            if (wb.valid && seen < expCount) begin
                expected.valid   = 1'b1;
                expected.destReg = regAddr_t'(stim[expBase + 2 * seen]);
                expected.data    = stim[expBase + 2 * seen + 1];
                checkWb(wb, expected);
                seen++;
            end else if (wb.valid) begin
                errorCount++;
                $display("Extra writeback to register %0d after the expected sequence",
                         wb.destReg);
            end else if (seen >= expCount) begin
                quiet++;
            end
        end
        run       = 1'b0;
        loadValid = 1'b0;
        @(negedge clk);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        int ptr;
        int progLen;
        int expCount;
        int errorsBefore;
        run        = 1'b0;
        loadValid  = 1'b0;
        load       = '0;
        seed       = 32'h73b6_c57e;
        errorCount = 0;
        checkCount = 0;
        testCount  = 0;
        $readmemh("tests/programInput.txt", stim);
        cycleLimit = cycleBudget();

        @(posedge arstN);
        @(negedge clk);

        ptr = 0;
        while (hasRecord(ptr)) begin
            progLen      = int'(stim[ptr]);
            expCount     = int'(stim[ptr + progLen + 1]);
            errorsBefore = errorCount;
            testCount++;
            loadProgram(ptr + 1, progLen);
            runProgram(ptr + progLen + 2, expCount);
            $display("Test %0d: %0d instructions, %0d writebacks, %s", testCount, progLen,
                     expCount, (errorCount == errorsBefore) ? "ok" : "mismatch");
            ptr = ptr + progLen + 2 + 2 * expCount;
        end

        if (testCount == 0) begin
            errorCount++;
            $display("No test records were found in the stimulus file");
        end
        $display("Tests: %0d  checks: %0d  errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycleCount);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

// ==== tests/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic o_clk,
    output logic o_arstN
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Release on a falling edge, clear of the active edge
    initial begin
        o_arstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_arstN = 1'b1;
    end

endmodule

// ==== src/mipsPipeline.sv ====
`timescale 1ns/1ps

module mipsPipeline
    import mipsPkg::*;
#(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_WORDS = 64
) (
    input  logic      i_clk,
    input  logic      i_arstN,
    input  logic      i_run,
    input  imemLoad_t i_load,
    input  logic      i_loadValid,
    output logic      o_loadReady,
    output wb_t       o_wb
);

    ifId_t  ifId;
    idEx_t  idEx;
    exMem_t exMem;
    logic   redirectValid;
    word_t  redirectPc;

    //////////////////////////////
    // Fetch
    //////////////////////////////
    fetchStage #(
        .IMEM_WORDS      (IMEM_WORDS)
    ) fetchStage_i (
        .i_clk           (i_clk),
        .i_arstN         (i_arstN),
        .i_run           (i_run),
        .i_load          (i_load),
        .i_loadValid     (i_loadValid),
        .o_loadReady     (o_loadReady),
        .i_redirectValid (redirectValid),
        .i_redirectPc    (redirectPc),
        .o_ifId          (ifId)
    );

    //////////////////////////////
    // Decode
    //////////////////////////////
    // Register file is written from the retiring instruction
    decodeStage decodeStage_i (
        .i_clk   (i_clk),
        .i_arstN (i_arstN),
        .i_run   (i_run),
        .i_ifId  (ifId),
        .i_wb    (o_wb),
        .o_idEx  (idEx)
    );

    //////////////////////////////
    // Execute
    //////////////////////////////
    executeStage executeStage_i (
        .i_clk   (i_clk),
        .i_arstN (i_arstN),
        .i_run   (i_run),
        .i_idEx  (idEx),
        .o_exMem (exMem)
    );

    //////////////////////////////
    // Memory and writeback
    //////////////////////////////
    memoryStage #(
        .DMEM_WORDS      (DMEM_WORDS)
    ) memoryStage_i (
        .i_clk           (i_clk),
        .i_arstN         (i_arstN),
        .i_run           (i_run),
        .i_exMem         (exMem),
        .o_redirectValid (redirectValid),
        .o_redirectPc    (redirectPc),
        .o_wb            (o_wb)
    );

endmodule

// ==== src/memoryStage.sv ====
`timescale 1ns/1ps

module memoryStage
    import mipsPkg::*;
#(
    parameter int DMEM_WORDS = 64
) (
    input  logic   i_clk,
    input  logic   i_arstN,
    input  logic   i_run,
    input  exMem_t i_exMem,
    output logic   o_redirectValid,
    output word_t  o_redirectPc,
    output wb_t    o_wb
);

    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    logic [DMEM_AW-1:0] wordIdx;
    word_t              memData;
    memWb_t             memWb;
    word_t              dmem [0:DMEM_WORDS-1];

    //////////////////////////////
    // Data memory
    //////////////////////////////
    assign wordIdx = i_exMem.aluResult[DMEM_AW+1:2];
    assign memData = i_exMem.ctrl.memRead ? dmem[wordIdx] : '0;

    always_ff @(posedge i_clk) begin
        if (i_run && i_exMem.ctrl.memWrite) begin
            dmem[wordIdx] <= i_exMem.storeData;
        end
    end

    // Taken beq, fetch picks this up on the next edge
    assign o_redirectValid = i_run && i_exMem.ctrl.branch && i_exMem.zero;
    assign o_redirectPc    = i_exMem.branchTarget;

    //////////////////////////////
    // MEM/WB register
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            memWb <= '0;
        end else if (!i_run) begin
            memWb <= '0;
        end else begin
            memWb.aluResult <= i_exMem.aluResult;
            memWb.memData   <= memData;
            memWb.destReg   <= i_exMem.destReg;
            memWb.ctrl      <= i_exMem.ctrl;
        end
    end

    // Writeback select, r0 writes never retire
    assign o_wb.valid   = i_run && memWb.ctrl.regWrite && (memWb.destReg != '0);
    assign o_wb.destReg = memWb.destReg;
    assign o_wb.data    = memWb.ctrl.memToReg ? memWb.memData : memWb.aluResult;

endmodule

// ==== src/executeStage.sv ====
`timescale 1ns/1ps

module executeStage
    import mipsPkg::*;
(
    input  logic   i_clk,
    input  logic   i_arstN,
    input  logic   i_run,
    input  idEx_t  i_idEx,
    output exMem_t o_exMem
);

    aluOp_e   aluSel;
    word_t    opA;
    word_t    opB;
    word_t    aluResult;
    logic     aluZero;
    regAddr_t destReg;
    word_t    branchTarget;

    //////////////////////////////
    // ALU decoder
    //////////////////////////////
    // regDst marks R-type, everything else keeps the decoder's choice
    always_comb begin
        aluSel = i_idEx.ctrl.aluOp;
        if (i_idEx.ctrl.regDst) begin
            case (i_idEx.funct)
                fnAdd:   aluSel = aluAdd;
                fnSub:   aluSel = aluSub;
                fnAnd:   aluSel = aluAnd;
                fnOr:    aluSel = aluOr;
                fnXor:   aluSel = aluXor;
                fnSlt:   aluSel = aluSlt;
                default: aluSel = aluAdd;
            endcase
        end
    end

    //////////////////////////////
    // Operands and ALU
    //////////////////////////////
    assign opA = i_idEx.rsData;
    assign opB = i_idEx.ctrl.aluSrc ? i_idEx.imm : i_idEx.rtData;

    always_comb begin
        case (aluSel)
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluXor:  aluResult = opA ^ opB;
            // Signed compare
            aluSlt:  aluResult = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            default: aluResult = '0;
        endcase
    end

    // Used by beq after the subtract
    assign aluZero = (aluResult == '0);

    // rd for R-type, rt for immediates and loads
    assign destReg = i_idEx.ctrl.regDst ? i_idEx.rd : i_idEx.rt;

    // Word offset relative to the next instruction
    assign branchTarget = i_idEx.pc4 + {i_idEx.imm[XLEN-3:0], 2'b00};

    //////////////////////////////
    // EX/MEM register
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_exMem <= '0;
        end else if (!i_run) begin
            o_exMem <= '0;
        end else begin
            o_exMem.branchTarget <= branchTarget;
            o_exMem.aluResult    <= aluResult;
            o_exMem.storeData    <= i_idEx.rtData;
            o_exMem.zero         <= aluZero;
            o_exMem.destReg      <= destReg;
            o_exMem.ctrl         <= i_idEx.ctrl;
        end
    end

endmodule

// ==== src/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage
    import mipsPkg::*;
(
    input  logic  i_clk,
    input  logic  i_arstN,
    input  logic  i_run,
    input  ifId_t i_ifId,
    input  wb_t   i_wb,
    output idEx_t o_idEx
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    opcode_e     opcode;
    regAddr_t    rs;
    regAddr_t    rt;
    regAddr_t    rd;
    logic [15:0] imm16;
    logic        zeroExt;
    word_t       immExt;
    ctrl_t       ctrl;
    word_t       rsData;
    word_t       rtData;
    word_t       regFile [0:NUM_REGS-1];

    // Instruction fields
    assign opcode = opcode_e'(i_ifId.instr[31:26]);
    assign rs     = i_ifId.instr[25:21];
    assign rt     = i_ifId.instr[20:16];
    assign rd     = i_ifId.instr[15:11];
    assign imm16  = i_ifId.instr[15:0];

    //////////////////////////////
    // Control decoder
    //////////////////////////////
    always_comb begin
        ctrl = '0;
        if (i_ifId.valid) begin
            case (opcode)
                // ALU operation comes from funct in execute
                opR: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.regDst   = 1'b1;
                end
                opLw: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.memRead  = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                end
                opSw: begin
                    ctrl.memWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                end
                opBeq: begin
                    ctrl.branch = 1'b1;
                    ctrl.aluOp  = aluSub;
                end
                opAddi: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                end
                opAndi: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.aluOp    = aluAnd;
                end
                opOri: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.aluOp    = aluOr;
                end
                opSlti: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.aluOp    = aluSlt;
                end
                default: ctrl = '0;
            endcase
        end
    end

    // Logical immediates are zero extended
    assign zeroExt = (opcode == opAndi) || (opcode == opOri);
    assign immExt  = zeroExt ? {{(XLEN-16){1'b0}}, imm16}
                             : {{(XLEN-16){imm16[15]}}, imm16};

    //////////////////////////////
    // Register file
    //////////////////////////////
    // r0 reads zero, same-cycle writeback passes straight through
    function automatic word_t readReg(input regAddr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (i_wb.valid && (i_wb.destReg == addr)) begin
            value = i_wb.data;
        end else begin
            value = regFile[addr];
        end
        return value;
    endfunction

    always_comb begin
        rsData = readReg(rs);
        rtData = readReg(rt);
    end

    always_ff @(posedge i_clk) begin
        if (i_wb.valid) begin
            regFile[i_wb.destReg] <= i_wb.data;
        end
    end

    //////////////////////////////
    // ID/EX register
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_idEx <= '0;
        end else if (!i_run) begin
            o_idEx <= '0;
        end else begin
            o_idEx.pc4    <= i_ifId.pc4;
            o_idEx.rsData <= rsData;
            o_idEx.rtData <= rtData;
            o_idEx.imm    <= immExt;
            o_idEx.rt     <= rt;
            o_idEx.rd     <= rd;
            o_idEx.funct  <= funct_e'(i_ifId.instr[5:0]);
            o_idEx.ctrl   <= ctrl;
        end
    end

endmodule

// ==== src/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage
    import mipsPkg::*;
#(
    parameter int IMEM_WORDS = 64
) (
    input  logic      i_clk,
    input  logic      i_arstN,
    input  logic      i_run,
    input  imemLoad_t i_load,
    input  logic      i_loadValid,
    output logic      o_loadReady,
    input  logic      i_redirectValid,
    input  word_t     i_redirectPc,
    output ifId_t     o_ifId
);

    localparam int IMEM_AW = $clog2(IMEM_WORDS);

    word_t pc;
    word_t pcPlus4;
    word_t nextPc;
    word_t fetchedInstr;
    word_t imem [0:IMEM_WORDS-1];

    //////////////////////////////
    // Instruction memory
    //////////////////////////////
    // Loading only while the core is stopped
    assign o_loadReady = !i_run;

    always_ff @(posedge i_clk) begin
        if (i_loadValid && o_loadReady) begin
            imem[i_load.addr[IMEM_AW-1:0]] <= i_load.data;
        end
    end

    // Combinational read from the registered PC
    assign fetchedInstr = imem[pc[IMEM_AW+1:2]];

    //////////////////////////////
    // Program counter
    //////////////////////////////
    assign pcPlus4 = pc + word_t'(4);

    // Taken beq from the memory stage wins
    assign nextPc = i_redirectValid ? i_redirectPc : pcPlus4;

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            pc <= '0;
        end else if (!i_run) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    //////////////////////////////
    // IF/ID register
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_ifId <= '0;
        end else if (!i_run) begin
            o_ifId <= '0;
        end else begin
            o_ifId.pc4   <= pcPlus4;
            o_ifId.instr <= fetchedInstr;
            o_ifId.valid <= 1'b1;
        end
    end

endmodule

// ==== src/mipsPkg.sv ====
package mipsPkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] regAddr_t;

    //////////////////////////////
    // Encodings
    //////////////////////////////
    // Standard MIPS opcode field values
    typedef enum logic [5:0] {
        opR    = 6'h00,
        opBeq  = 6'h04,
        opAddi = 6'h08,
        opSlti = 6'h0A,
        opAndi = 6'h0C,
        opOri  = 6'h0D,
        opLw   = 6'h23,
        opSw   = 6'h2B
    } opcode_e;

    // R-type funct field values
    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnXor = 6'h26,
        fnSlt = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluSlt = 3'd5
    } aluOp_e;

    //////////////////////////////
    // Stage registers
    //////////////////////////////
    // All zero is a bubble
    typedef struct packed {
        logic   regWrite;
        logic   memToReg;
        logic   branch;
        logic   memRead;
        logic   memWrite;
        logic   aluSrc;
        logic   regDst;
        aluOp_e aluOp;
    } ctrl_t;

    typedef struct packed {
        word_t pc4;
        word_t instr;
        logic  valid;
    } ifId_t;

    typedef struct packed {
        word_t    pc4;
        word_t    rsData;
        word_t    rtData;
        word_t    imm;
        regAddr_t rt;
        regAddr_t rd;
        funct_e   funct;
        ctrl_t    ctrl;
    } idEx_t;

    typedef struct packed {
        word_t    branchTarget;
        word_t    aluResult;
        word_t    storeData;
        logic     zero;
        regAddr_t destReg;
        ctrl_t    ctrl;
    } exMem_t;

    typedef struct packed {
        word_t    aluResult;
        word_t    memData;
        regAddr_t destReg;
        ctrl_t    ctrl;
    } memWb_t;

    // Retiring write, also drives the register file
    typedef struct packed {
        logic     valid;
        regAddr_t destReg;
        word_t    data;
    } wb_t;

    // Addr is a word index into instruction memory
    typedef struct packed {
        word_t addr;
        word_t data;
    } imemLoad_t;

endpackage
